/* rtl/acc_defs.svh */
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

// Machine word width
`define ACC_WORD_BITS 16

// Word address width, one address per word
`define ACC_ADDR_BITS 12

// Program and data share this many words
`define ACC_MEM_WORDS 4096

`endif

/* rtl/machine_pkg.sv */
`default_nettype none

`include "acc_defs.svh"

package machine_pkg;

    // One data or instruction word
    typedef logic [`ACC_WORD_BITS-1:0] word_t;

    // One word address into the unified memory
    typedef logic [`ACC_ADDR_BITS-1:0] addr_t;

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        OP_LOAD  = 4'd0,
        OP_STORE = 4'd1,
        OP_ADD   = 4'd2,
        OP_SUB   = 4'd3,
        OP_AND   = 4'd4,
        OP_JUMP  = 4'd5,
        OP_JZ    = 4'd6,
        OP_ALUI  = 4'd7,
        OP_HALT  = 4'd8,
        OP_NOP   = 4'd15    // Codes 9 to 14 decode the same way
    } major_op_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_DIV  = 4'd3,
        ALU_SHL  = 4'd4,
        ALU_SHR  = 4'd5,
        ALU_ROL  = 4'd6,
        ALU_ROR  = 4'd7,
        ALU_AND  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_NOR  = 4'd11,
        ALU_NAND = 4'd12,
        ALU_XNOR = 4'd13,
        ALU_GT   = 4'd14,
        ALU_EQ   = 4'd15
    } alu_op_t;

    typedef struct packed {
        major_op_t          op;
        machine_pkg::addr_t addr;   // Operand address or jump target
    } mem_fmt_t;

    typedef struct packed {
        major_op_t  op;
        alu_op_t    alu_op;
        logic [7:0] imm;    // Zero-extended into operand2
    } alu_fmt_t;

    // Same 16-bit word, two views
    typedef union packed {
        mem_fmt_t mem;
        alu_fmt_t alu;
    } instr_u;

endpackage

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu (
    input  wire isa_pkg::alu_op_t   op,
    input  wire machine_pkg::word_t operand1,
    input  wire machine_pkg::word_t operand2,
    output machine_pkg::word_t      result
);
    import isa_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = operand1 + operand2;
            ALU_SUB:  result = operand1 - operand2;
            ALU_MUL:  result = operand1 * operand2;     // Low half of the product
            ALU_DIV: begin
                if (operand2 == '0) begin
                    result = '1;
                end else begin
                    result = operand1 / operand2;
                end
            end
            ALU_SHL:  result = operand1 << 1;
            ALU_SHR:  result = operand1 >> 1;           // Logical, zero fill
            ALU_ROL:  result = {operand1[14:0], operand1[15]};
            ALU_ROR:  result = {operand1[0], operand1[15:1]};
            ALU_AND:  result = operand1 & operand2;
            ALU_OR:   result = operand1 | operand2;
            ALU_XOR:  result = operand1 ^ operand2;
            ALU_NOR:  result = ~(operand1 | operand2);
            ALU_NAND: result = ~(operand1 & operand2);
            ALU_XNOR: result = ~(operand1 ^ operand2);
            ALU_GT:   result = (operand1 > operand2) ? 16'd1 : 16'd0;  // Unsigned compare
            ALU_EQ:   result = (operand1 == operand2) ? 16'd1 : 16'd0;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/unified_memory.sv */
`default_nettype none

`include "acc_defs.svh"

module unified_memory (
    input  wire                     clock,
    input  wire                     run,
    input  wire machine_pkg::addr_t fetch_addr,
    output machine_pkg::word_t      fetch_word,
    input  wire machine_pkg::addr_t data_rd_addr,
    output machine_pkg::word_t      data_rdata,
    input  wire                     data_we,
    input  wire machine_pkg::addr_t data_wr_addr,
    input  wire machine_pkg::word_t data_wdata,
    input  wire                     host_we,
    input  wire machine_pkg::addr_t host_addr,
    input  wire machine_pkg::word_t host_wdata,
    output machine_pkg::word_t      host_rdata
);
    import machine_pkg::*;

    word_t mem [`ACC_MEM_WORDS];

    addr_t port_rd_addr;
    addr_t port_wr_addr;
    logic  port_we;
    word_t port_wdata;
    word_t port_rdata;

    // Host owns the data port while the core is stopped
    assign port_rd_addr = run ? data_rd_addr : host_addr;
    assign port_wr_addr = run ? data_wr_addr : host_addr;
    assign port_we      = run ? data_we      : host_we;
    assign port_wdata   = run ? data_wdata   : host_wdata;

    always_ff @(posedge clock) begin
        fetch_word <= mem[fetch_addr];
        port_rdata <= mem[port_rd_addr];    // Old data on a same-address write
        if (port_we) begin
            mem[port_wr_addr] <= port_wdata;
        end
    end

    assign data_rdata = port_rdata;
    assign host_rdata = port_rdata;

    // Host writes while running would race the core's stores
    host_write_only_when_stopped: assert property (@(posedge clock) run |-> !host_we)
        else $error("host write while run is high");

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire                     halted,
    input  wire                     redirect,
    input  wire machine_pkg::addr_t redirect_target,
    output machine_pkg::addr_t      fetch_addr,
    output logic                    fetch_valid
);
    import machine_pkg::*;

    addr_t pc;

    // The PC is the fetch address and the word comes back next cycle
    assign fetch_addr = pc;

    always_ff @(posedge clock) begin
        if (!rst_n || !run) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            // Word addressed this cycle is wrong if a branch was taken
            fetch_valid <= !halted && !redirect;
            if (redirect) begin
                pc <= redirect_target;
            end else if (!halted) begin
                pc <= pc + addr_t'(1);  // Wraps at the top of memory
            end
        end
    end

    fetch_addr_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(fetch_addr)
    ) else $error("fetch address unknown");

endmodule

`default_nettype wire

/* rtl/operand_stage.sv */
`default_nettype none

module operand_stage (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire machine_pkg::word_t fetch_word,
    input  wire                     fetch_valid,
    input  wire                     redirect,
    output machine_pkg::addr_t      data_rd_addr,
    output machine_pkg::word_t      op_word,
    output logic                    op_valid
);
    import isa_pkg::*;

    instr_u fetched;
    logic   reads_memory;

    assign fetched = fetch_word;

    // Only these four need the memory word in execute
    always_comb begin
        case (fetched.mem.op)
            OP_LOAD, OP_ADD, OP_SUB, OP_AND: reads_memory = 1'b1;
            default:                         reads_memory = 1'b0;
        endcase
    end

    assign data_rd_addr = (fetch_valid && reads_memory) ? fetched.mem.addr : '0;

    always_ff @(posedge clock) begin
        if (!rst_n || !run) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= fetch_valid && !redirect;   // Squash behind a taken branch
        end
    end

    always_ff @(posedge clock) begin
        op_word <= fetch_word;
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire machine_pkg::word_t op_word,
    input  wire                     op_valid,
    input  wire machine_pkg::word_t data_rdata,
    output logic                    data_we,
    output machine_pkg::addr_t      data_wr_addr,
    output machine_pkg::word_t      data_wdata,
    output logic                    redirect,
    output machine_pkg::addr_t      redirect_target,
    output machine_pkg::word_t      acc,
    output logic                    halted
);
    import machine_pkg::*;
    import isa_pkg::*;

    instr_u  instr;
    logic    exec_valid;
    logic    last_store_valid;
    addr_t   last_store_addr;
    logic    fwd_hit;
    word_t   mem_operand;
    alu_op_t alu_sel;
    word_t   alu_b;
    word_t   alu_result;

    assign instr      = op_word;
    assign exec_valid = op_valid && !halted;    // Nothing retires after HALT

    // Memory read this operand before last cycle's store landed
    assign fwd_hit     = last_store_valid && (last_store_addr == instr.mem.addr);
    assign mem_operand = fwd_hit ? acc : data_rdata;

    always_comb begin
        alu_sel = ALU_ADD;
        alu_b   = mem_operand;
        case (instr.mem.op)
            OP_SUB:  alu_sel = ALU_SUB;
            OP_AND:  alu_sel = ALU_AND;
            OP_ALUI: begin
                alu_sel = instr.alu.alu_op;
                alu_b   = {8'd0, instr.alu.imm};
            end
            default: alu_sel = ALU_ADD;
        endcase
    end

    alu u_alu (
        .op       (alu_sel),
        .operand1 (acc),
        .operand2 (alu_b),
        .result   (alu_result)
    );

    // Store goes out in the execute cycle itself
    assign data_we      = exec_valid && (instr.mem.op == OP_STORE);
    assign data_wr_addr = instr.mem.addr;
    assign data_wdata   = acc;

    assign redirect = exec_valid &&
                      ((instr.mem.op == OP_JUMP) || ((instr.mem.op == OP_JZ) && (acc == '0)));
    assign redirect_target = instr.mem.addr;

    always_ff @(posedge clock) begin
        if (!rst_n || !run) begin
            acc              <= '0;
            halted           <= 1'b0;
            last_store_valid <= 1'b0;
        end else begin
            last_store_valid <= data_we;    // Only the very next instruction can miss it
            if (exec_valid) begin
                case (instr.mem.op)
                    OP_LOAD:                         acc <= mem_operand;
                    OP_ADD, OP_SUB, OP_AND, OP_ALUI: acc <= alu_result;
                    OP_HALT:                         halted <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        last_store_addr <= data_wr_addr;
    end

    no_store_on_redirect: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(redirect && data_we)
    ) else $error("redirect and store in the same cycle");

    halt_is_sticky: assert property (
        @(posedge clock) disable iff (!rst_n)
        (halted && run) ##1 run |-> halted
    ) else $error("halted fell while run stayed high");

endmodule

`default_nettype wire

/* rtl/acc_computer.sv */
`default_nettype none

module acc_computer (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire                     host_we,
    input  wire machine_pkg::addr_t host_addr,
    input  wire machine_pkg::word_t host_wdata,
    output machine_pkg::word_t      host_rdata,
    output machine_pkg::word_t      acc,
    output logic                    halted
);
    import machine_pkg::*;

    addr_t fetch_addr;
    word_t fetch_word;
    logic  fetch_valid;
    addr_t data_rd_addr;
    word_t data_rdata;
    logic  data_we;
    addr_t data_wr_addr;
    word_t data_wdata;
    word_t op_word;
    logic  op_valid;
    logic  redirect;
    addr_t redirect_target;

    unified_memory u_memory (
        .clock        (clock),
        .run          (run),
        .fetch_addr   (fetch_addr),
        .fetch_word   (fetch_word),
        .data_rd_addr (data_rd_addr),
        .data_rdata   (data_rdata),
        .data_we      (data_we),
        .data_wr_addr (data_wr_addr),
        .data_wdata   (data_wdata),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata)
    );

    fetch_stage u_fetch (
        .clock           (clock),
        .rst_n           (rst_n),
        .run             (run),
        .halted          (halted),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetch_addr      (fetch_addr),
        .fetch_valid     (fetch_valid)
    );

    operand_stage u_operand (
        .clock        (clock),
        .rst_n        (rst_n),
        .run          (run),
        .fetch_word   (fetch_word),
        .fetch_valid  (fetch_valid),
        .redirect     (redirect),
        .data_rd_addr (data_rd_addr),
        .op_word      (op_word),
        .op_valid     (op_valid)
    );

    execute_stage u_execute (
        .clock           (clock),
        .rst_n           (rst_n),
        .run             (run),
        .op_word         (op_word),
        .op_valid        (op_valid),
        .data_rdata      (data_rdata),
        .data_we         (data_we),
        .data_wr_addr    (data_wr_addr),
        .data_wdata      (data_wdata),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .acc             (acc),
        .halted          (halted)
    );

endmodule

`default_nettype wire

/* dv/acc_computer_tb.sv */
`default_nettype none

module acc_computer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import machine_pkg::*;
    import isa_pkg::*;

    localparam int IMAGE_WORDS   = 256;     // Every test image lives in the low words
    localparam logic [11:0] DATA = 12'h080;
    localparam int HALT_TIMEOUT  = 2000;
    localparam int MODEL_STEPS   = 1000;

    logic   clock;
    logic   rst_n;
    logic   run;
    logic   host_we;
    addr_t  host_addr;
    word_t  host_wdata;
    word_t  host_rdata;
    word_t  acc;
    logic   halted;
    word_t  image [IMAGE_WORDS];
    word_t  model_mem [IMAGE_WORDS];
    int     emit_pc;
    integer seed;

    acc_computer UUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .run        (run),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .acc        (acc),
        .halted     (halted)
    );

    always #2 clock = ~clock;   // 4 ns period

    function automatic word_t alu_ref(input logic [3:0] sel, input word_t a, input word_t b);
        word_t r;
        case (sel)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_MUL:  r = a * b;
            ALU_DIV:  r = (b == 16'd0) ? 16'hFFFF : a / b;
            ALU_SHL:  r = {a[14:0], 1'b0};
            ALU_SHR:  r = {1'b0, a[15:1]};
            ALU_ROL:  r = (a << 1) | (a >> 15);
            ALU_ROR:  r = (a >> 1) | (a << 15);
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NOR:  r = ~(a | b);
            ALU_NAND: r = ~(a & b);
            ALU_XNOR: r = ~(a ^ b);
            ALU_GT:   r = {15'd0, a > b};
            default:  r = {15'd0, a == b};
        endcase
        return r;
    endfunction

    // Sequential ISA interpreter over the same image, fills model_mem
    function automatic word_t run_model();
        word_t      m_acc;
        word_t      ins;
        logic [7:0] pc;
        logic [7:0] ea;
        bit         done;
        int         steps;
        int         a;
        m_acc = 16'd0;
        pc    = 8'd0;
        done  = 1'b0;
        steps = 0;
        for (a = 0; a < IMAGE_WORDS; a++) begin
            model_mem[a] = image[a];
        end
        while (!done && steps < MODEL_STEPS) begin
            ins = model_mem[pc];
            ea  = ins[7:0];     // Addresses and targets stay below 256
            pc  = pc + 8'd1;
            steps++;
            case (ins[15:12])
                OP_LOAD:  m_acc = model_mem[ea];
                OP_STORE: model_mem[ea] = m_acc;
                OP_ADD:   m_acc = alu_ref(ALU_ADD, m_acc, model_mem[ea]);
                OP_SUB:   m_acc = alu_ref(ALU_SUB, m_acc, model_mem[ea]);
                OP_AND:   m_acc = alu_ref(ALU_AND, m_acc, model_mem[ea]);
                OP_JUMP:  pc = ea;
                OP_JZ:    pc = (m_acc == 16'd0) ? ea : pc;
                OP_ALUI:  m_acc = alu_ref(ins[11:8], m_acc, {8'd0, ins[7:0]});
                OP_HALT:  done = 1'b1;
                default:  ;     // Codes 9 to 15 do nothing
            endcase
        end
        return m_acc;
    endfunction

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            fail_now($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic clear_image();
        int a;
        for (a = 0; a < IMAGE_WORDS; a++) begin
            image[a] = 16'hF000 | word_t'(a);  // NOP carrying its own address
        end
        emit_pc = 0;
    endtask

    task automatic emit(input logic [3:0] major, input logic [11:0] field);
        image[emit_pc] = {major, field};
        emit_pc++;
    endtask

    task automatic load_image();
        int a;
        for (a = 0; a < IMAGE_WORDS; a++) begin
            @(negedge clock);
            host_we    = 1'b1;
            host_addr  = addr_t'(a);
            host_wdata = image[a];
        end
        @(negedge clock);
        host_we = 1'b0;
    endtask

    // Reads back through the host port while run is low
    task automatic compare_memory(input bit against_model);
        int a;
        for (a = 0; a < IMAGE_WORDS; a++) begin
            @(negedge clock);
            host_addr = addr_t'(a);
            @(negedge clock);
            check_word($sformatf("word %0h", a), host_rdata,
                       against_model ? model_mem[a] : image[a]);
        end
    endtask

    task automatic run_and_compare(input string name, input int hold_cycles);
        word_t exp_acc;
        int    cycles;
        @(negedge clock);
        run    = 1'b1;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            fail_now($sformatf("%s: halted never rose within %0d cycles", name, HALT_TIMEOUT));
        end
        repeat (hold_cycles) begin
            @(negedge clock);
            assert (halted) else fail_now($sformatf("%s: halted dropped while running", name));
        end
        exp_acc = run_model();
        check_word({name, " acc"}, acc, exp_acc);
        @(negedge clock);
        run = 1'b0;
        compare_memory(1'b1);
    endtask

    task automatic build_alu_program();
        int k;
        clear_image();
        for (k = 0; k < 16; k++) begin
            emit(OP_LOAD, DATA + 12'(k));
            emit(OP_ALUI, {4'(k), 8'(k * 37 + 5)});
            emit(OP_STORE, 12'h0A0 + 12'(k));
        end
        emit(OP_LOAD, 12'h083);
        emit(OP_ALUI, {ALU_DIV, 8'h00});    // Divide by zero
        emit(OP_STORE, 12'h0B0);
        emit(OP_ALUI, {ALU_AND, 8'h00});
        emit(OP_ALUI, {ALU_EQ, 8'h00});
        emit(OP_STORE, 12'h0B1);
        emit(OP_ALUI, {ALU_GT, 8'h00});
        emit(OP_ALUI, {ALU_GT, 8'h05});
        emit(OP_ALUI, {ALU_NOR, 8'h00});
        emit(OP_ALUI, {ALU_ROL, 8'h00});
        emit(OP_STORE, 12'h0B2);
        emit(OP_HALT, 12'h000);
    endtask

    task automatic build_memory_program();
        clear_image();
        emit(OP_LOAD, 12'h080);
        emit(OP_ADD, 12'h081);
        emit(OP_SUB, 12'h082);
        emit(OP_AND, 12'h083);
        emit(OP_STORE, 12'h084);
        emit(OP_LOAD, 12'h084);     // Needs the forwarded store
        emit(OP_ADD, 12'h084);
        emit(OP_STORE, 12'h085);
        emit(OP_ADD, 12'h085);
        emit(OP_STORE, 12'h086);
        emit(OP_STORE, 12'h087);
        emit(OP_LOAD, 12'h086);     // Store two back needs no forwarding
        emit(OP_SUB, 12'h087);
        emit(OP_STORE, 12'h088);
        emit(OP_HALT, 12'h000);
    endtask

    task automatic build_branch_program();
        clear_image();
        emit(OP_LOAD, 12'h080);             // 0
        emit(OP_JUMP, 12'h005);             // 1
        emit(OP_STORE, 12'h090);            // 2 squashed
        emit(OP_STORE, 12'h091);            // 3 squashed
        emit(OP_STORE, 12'h092);            // 4 skipped
        emit(OP_JZ, 12'h009);               // 5 not taken
        emit(OP_STORE, 12'h093);            // 6
        emit(OP_ALUI, {ALU_AND, 8'h00});    // 7
        emit(OP_JZ, 12'h00C);               // 8 taken
        emit(OP_STORE, 12'h094);            // 9 squashed
        emit(OP_STORE, 12'h095);            // 10 squashed
        emit(OP_ALUI, {ALU_ADD, 8'h77});    // 11 skipped
        emit(OP_ALUI, {ALU_ADD, 8'h11});    // 12
        emit(OP_STORE, 12'h096);            // 13
        emit(OP_JUMP, 12'h011);             // 14
        emit(OP_STORE, 12'h097);            // 15 squashed
        emit(OP_STORE, 12'h098);            // 16 squashed
        emit(OP_HALT, 12'h000);             // 17
    endtask

    task automatic build_halt_program();
        clear_image();
        emit(OP_LOAD, 12'h081);
        emit(OP_ALUI, {ALU_XOR, 8'h5A});
        emit(OP_STORE, 12'h090);
        emit(OP_HALT, 12'h000);
        emit(OP_STORE, 12'h091);    // Nothing from here on retires
        emit(OP_STORE, 12'h092);
        emit(OP_ALUI, {ALU_ADD, 8'h01});
        emit(OP_STORE, 12'h093);
        emit(OP_STORE, 12'h081);
    endtask

    task automatic build_random_program();
        int          a;
        int          n;
        logic [31:0] r;
        logic [11:0] addr;
        clear_image();
        for (a = 0; a < 16; a++) begin
            r = $random(seed);
            image[int'(DATA) + a] = r[15:0];
        end
        r = $random(seed);
        n = 8 + int'(r[4:0]);
        for (a = 0; a < n; a++) begin
            r    = $random(seed);
            addr = DATA + {8'd0, r[7:4]};
            case (r[2:0])
                3'd0:    emit(OP_LOAD, addr);
                3'd1:    emit(OP_STORE, addr);
                3'd2:    emit(OP_ADD, addr);
                3'd3:    emit(OP_SUB, addr);
                3'd4:    emit(OP_AND, addr);
                default: emit(OP_ALUI, {r[15:12], r[23:16]});
            endcase
        end
        emit(OP_HALT, 12'h000);
    endtask

    initial begin
        int t;
        clock      = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'h5794_4edd;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_word("acc after reset", acc, 16'd0);
        check_word("halted after reset", {15'd0, halted}, 16'd0);

        build_alu_program();
        load_image();
        compare_memory(1'b0);   // Host write then host read
        run_and_compare("alu ops", 4);

        build_memory_program();
        load_image();
        run_and_compare("memory ops", 4);

        build_branch_program();
        load_image();
        run_and_compare("branches", 4);

        build_halt_program();
        load_image();
        run_and_compare("halt", 20);

        for (t = 0; t < 20; t++) begin
            build_random_program();
            load_image();
            run_and_compare($sformatf("random %0d", t), 2);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/machine_pkg.sv
rtl/isa_pkg.sv
rtl/alu.sv
rtl/unified_memory.sv
rtl/fetch_stage.sv
rtl/operand_stage.sv
rtl/execute_stage.sv
rtl/acc_computer.sv
dv/acc_computer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the accumulator computer testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module acc_computer_tb -f flist.f &&
./obj_dir/Vacc_computer_tb | tee /dev/stderr |
    grep "Test completed successfully" > /dev/null &&
echo "PASS" || { echo "FAIL"; exit 1; }
